// File: design/ex_alu_unit.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_alu_unit (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            op_valid_i,
    input  ex_pkg::ex_op_t  op_i,
    output logic            res_valid_o,
    output ex_pkg::ex_res_t res_o
);
    import ex_pkg::*;

    localparam int MSB = `EX_XLEN - 1;
    localparam int NW  = $clog2(`EX_XLEN + 1);

    word_t         a;
    word_t         b;
    word_t         sum;
    word_t         diff;
    word_t         result;
    logic          ovf;
    logic          wr_ok;
    logic          zero_run;
    logic          one_run;
    logic [NW-1:0] clz_cnt;
    logic [NW-1:0] clo_cnt;

    assign a    = op_i.rs_val;
    assign b    = op_i.rt_val;
    assign sum  = a + b;
    assign diff = a - b;

    // leading zeros/ones from the msb down
    always_comb begin
        zero_run = 1'b1;
        one_run  = 1'b1;
        clz_cnt  = '0;
        clo_cnt  = '0;
        for (int i = MSB; i >= 0; i--) begin
            zero_run = zero_run & ~a[i];
            one_run  = one_run & a[i];
            clz_cnt  = clz_cnt + NW'(zero_run);
            clo_cnt  = clo_cnt + NW'(one_run);
        end
    end

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        wr_ok  = 1'b1;
        case (op_i.op)
            op_or:   result = a | b;
            op_and:  result = a & b;
            op_xor:  result = a ^ b;
            op_nor:  result = ~(a | b);
            op_sll:  result = a << b[4:0];      // shift amount from rt
            op_srl:  result = a >> b[4:0];
            op_sra:  result = $signed(a) >>> b[4:0];
            op_movn: begin
                result = a;
                wr_ok  = (b != '0);
            end
            op_movz: begin
                result = a;
                wr_ok  = (b == '0);
            end
            op_add: begin
                result = sum;
                ovf    = (~a[MSB] & ~b[MSB] & sum[MSB]) | (a[MSB] & b[MSB] & ~sum[MSB]);
            end
            op_addu: result = sum;
            op_sub: begin
                result = diff;
                ovf    = (~a[MSB] & b[MSB] & diff[MSB]) | (a[MSB] & ~b[MSB] & ~diff[MSB]);
            end
            op_subu: result = diff;
            op_slt:  result = word_t'($signed(a) < $signed(b));
            op_sltu: result = word_t'(a < b);
            op_mul:  result = $signed(a) * $signed(b);     // low word only
            op_clz:  result = word_t'(clz_cnt);
            op_clo:  result = word_t'(clo_cnt);
            default: wr_ok = 1'b0;                          // nop writes nothing
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= op_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            res_o.waddr <= op_i.waddr;
            res_o.we    <= op_i.we & wr_ok & ~ovf;    // overflow drops the write
            res_o.data  <= result;
            res_o.ovf   <= ovf;
        end
    end

endmodule

// File: design/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data path width
`define EX_XLEN 32

// issue buffer depth, also the upstream credits after reset
`define EX_IN_DEPTH 4

// ALU result queue in the merger, also the ALU credits held by issue
`define EX_ALU_Q_DEPTH 4

// order queue in the merger
`define EX_ORDER_DEPTH 8

// credits toward writeback after reset
`define EX_OUT_CREDITS 2

`endif

// File: design/ex_issue.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_issue (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              op_valid_i,
    input  ex_pkg::ex_op_t    op_i,
    input  logic              alu_credit_i,
    input  logic              md_credit_i,
    output logic              op_credit_o,
    output logic              alu_valid_o,
    output ex_pkg::ex_op_t    alu_op_o,
    output logic              md_valid_o,
    output ex_pkg::ex_op_t    md_op_o,
    output logic              ord_push_o,
    output ex_pkg::unit_sel_e ord_sel_o
);
    import ex_pkg::*;

    localparam int PW = $clog2(`EX_IN_DEPTH);       // depth is a power of two
    localparam int CW = $clog2(`EX_IN_DEPTH + 1);
    localparam int AW = $clog2(`EX_ALU_Q_DEPTH + 1);

    ex_op_t        op_buf_q [`EX_IN_DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] cnt_q;
    logic [AW-1:0] alu_cred_q;
    logic          md_cred_q;                       // the md unit takes one op at a time
    ex_op_t        head;
    unit_sel_e     head_sel;
    logic          head_ok;
    logic          dispatch;
    logic          disp_alu;
    logic          disp_md;

    assign head     = op_buf_q[rd_ptr_q];
    assign head_sel = is_muldiv_op(head.op);
    assign head_ok  = (head_sel == sel_alu) ? (alu_cred_q != '0) : md_cred_q;
    assign dispatch = (cnt_q != '0) && head_ok;
    assign disp_alu = dispatch && (head_sel == sel_alu);
    assign disp_md  = dispatch && (head_sel == sel_muldiv);

    assign op_credit_o = dispatch;                  // slot freed, credit back upstream
    assign alu_valid_o = disp_alu;
    assign alu_op_o    = head;
    assign md_valid_o  = disp_md;
    assign md_op_o     = head;
    assign ord_push_o  = dispatch;
    assign ord_sel_o   = head_sel;

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            op_buf_q[wr_ptr_q] <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            cnt_q      <= '0;
            alu_cred_q <= AW'(`EX_ALU_Q_DEPTH);
            md_cred_q  <= 1'b1;
        end else begin
            wr_ptr_q   <= wr_ptr_q + PW'(op_valid_i);
            rd_ptr_q   <= rd_ptr_q + PW'(dispatch);
            cnt_q      <= cnt_q + CW'(op_valid_i) - CW'(dispatch);
            alu_cred_q <= alu_cred_q + AW'(alu_credit_i) - AW'(disp_alu);
            if (md_credit_i) begin
                md_cred_q <= 1'b1;
            end else if (disp_md) begin
                md_cred_q <= 1'b0;
            end
        end
    end

endmodule

// File: design/ex_muldiv_unit.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_muldiv_unit (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            op_valid_i,
    input  ex_pkg::ex_op_t  op_i,
    output logic            res_valid_o,
    output ex_pkg::ex_res_t res_o
);
    import ex_pkg::*;

    localparam int XLEN   = `EX_XLEN;
    localparam int STEP_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        st_idle,
        st_macc_add,
        st_div_run
    } md_state_e;

    md_state_e       state_q;
    dword_t          hilo_q;
    word_t           hi;
    word_t           lo;
    dword_t          prod_s;
    dword_t          prod_u;
    dword_t          prod_q;        // product held for the accumulate cycle
    logic            macc_sub_q;
    logic            start;
    logic            is_macc;
    logic            is_div;
    logic            a_neg;
    logic            b_neg;
    logic [STEP_W-1:0] step_q;
    word_t           rem_q;
    word_t           quo_q;         // dividend shifts out as quotient shifts in
    word_t           dvsr_q;
    logic            neg_quo_q;
    logic            neg_rem_q;
    logic            dvsr_zero_q;
    logic [XLEN:0]   rem_sh;
    logic [XLEN+1:0] trial;
    word_t           rem_nxt;
    word_t           quo_nxt;
    word_t           rem_fix;
    word_t           quo_fix;
    logic            last_step;

    assign hi      = hilo_q[XLEN +: XLEN];
    assign lo      = hilo_q[0 +: XLEN];
    assign start   = (state_q == st_idle) && op_valid_i;
    assign is_macc = op_i.op inside {op_madd, op_maddu, op_msub, op_msubu};
    assign is_div  = op_i.op inside {op_div, op_divu};
    assign a_neg   = (op_i.op == op_div) && op_i.rs_val[XLEN-1];
    assign b_neg   = (op_i.op == op_div) && op_i.rt_val[XLEN-1];
    assign prod_s  = $signed(op_i.rs_val) * $signed(op_i.rt_val);
    assign prod_u  = op_i.rs_val * op_i.rt_val;

    // one restoring step on magnitudes
    assign rem_sh    = {rem_q, quo_q[XLEN-1]};
    assign trial     = {1'b0, rem_sh} - {2'b00, dvsr_q};
    assign rem_nxt   = trial[XLEN+1] ? rem_sh[XLEN-1:0] : trial[XLEN-1:0];
    assign quo_nxt   = {quo_q[XLEN-2:0], ~trial[XLEN+1]};
    assign quo_fix   = neg_quo_q ? -quo_nxt : quo_nxt;
    assign rem_fix   = neg_rem_q ? -rem_nxt : rem_nxt;    // remainder follows dividend
    assign last_step = (state_q == st_div_run) && (step_q == STEP_W'(XLEN - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= st_idle;
            step_q      <= '0;
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    step_q <= '0;
                    if (op_valid_i && is_macc) begin
                        state_q <= st_macc_add;
                    end else if (op_valid_i && is_div) begin
                        state_q <= st_div_run;
                    end else if (op_valid_i) begin
                        res_valid_o <= 1'b1;
                    end
                end
                st_macc_add: begin
                    state_q     <= st_idle;
                    res_valid_o <= 1'b1;
                end
                st_div_run: begin
                    step_q <= step_q + 1'b1;
                    if (last_step) begin
                        state_q     <= st_idle;
                        res_valid_o <= 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo_q <= '0;
        end else if (start) begin
            case (op_i.op)
                op_mthi:  hilo_q[XLEN +: XLEN] <= op_i.rs_val;
                op_mtlo:  hilo_q[0 +: XLEN]    <= op_i.rs_val;
                op_mult:  hilo_q <= prod_s;
                op_multu: hilo_q <= prod_u;
                default:  hilo_q <= hilo_q;
            endcase
        end else if (state_q == st_macc_add) begin
            hilo_q <= macc_sub_q ? hilo_q - prod_q : hilo_q + prod_q;
        end else if (last_step && !dvsr_zero_q) begin
            hilo_q <= {rem_fix, quo_fix};               // hi gets remainder
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            prod_q      <= (op_i.op inside {op_madd, op_msub}) ? prod_s : prod_u;
            macc_sub_q  <= op_i.op inside {op_msub, op_msubu};
            rem_q       <= '0;
            quo_q       <= a_neg ? -op_i.rs_val : op_i.rs_val;
            dvsr_q      <= b_neg ? -op_i.rt_val : op_i.rt_val;
            neg_quo_q   <= a_neg ^ b_neg;
            neg_rem_q   <= a_neg;
            dvsr_zero_q <= (op_i.rt_val == '0);
            res_o.waddr <= op_i.waddr;
            res_o.we    <= op_i.we && (op_i.op inside {op_mfhi, op_mflo});
            res_o.data  <= (op_i.op == op_mfhi) ? hi : (op_i.op == op_mflo) ? lo : '0;
            res_o.ovf   <= 1'b0;
        end else if (state_q == st_div_run) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

endmodule

// File: design/ex_pkg.sv
`include "ex_cfg.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0] word_t;      // one register word
    typedef logic [2*`EX_XLEN-1:0] dword_t;   // hi/lo pair
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [4:0] {
        op_nop,
        // logic and shift
        op_or, op_and, op_xor, op_nor,
        op_sll, op_srl, op_sra,
        // conditional move
        op_movn, op_movz,
        // arithmetic
        op_add, op_addu, op_sub, op_subu,
        op_slt, op_sltu, op_mul, op_clz, op_clo,
        // hi/lo access and multiply
        op_mthi, op_mtlo, op_mfhi, op_mflo,
        op_mult, op_multu,
        op_madd, op_maddu, op_msub, op_msubu,
        op_div, op_divu
    } alu_op_e;

    typedef enum logic {
        sel_alu,
        sel_muldiv
    } unit_sel_e;

    typedef struct packed {
        alu_op_e   op;
        word_t     rs_val;
        word_t     rt_val;
        reg_addr_t waddr;
        logic      we;
    } ex_op_t;

    typedef struct packed {
        reg_addr_t waddr;
        logic      we;
        word_t     data;
        logic      ovf;     // signed add/sub overflow
    } ex_res_t;

    // which unit executes an operation
    function automatic unit_sel_e is_muldiv_op(alu_op_e op);
        case (op)
            op_mthi, op_mtlo, op_mfhi, op_mflo,
            op_mult, op_multu,
            op_madd, op_maddu, op_msub, op_msubu,
            op_div, op_divu: return sel_muldiv;
            default:         return sel_alu;
        endcase
    endfunction

endpackage

// File: design/ex_result_merge.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_result_merge (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              ord_push_i,
    input  ex_pkg::unit_sel_e ord_sel_i,
    input  logic              alu_res_valid_i,
    input  ex_pkg::ex_res_t   alu_res_i,
    input  logic              md_res_valid_i,
    input  ex_pkg::ex_res_t   md_res_i,
    input  logic              res_credit_i,
    output logic              alu_credit_o,
    output logic              md_credit_o,
    output logic              res_valid_o,
    output ex_pkg::ex_res_t   res_o
);
    import ex_pkg::*;

    // queue depths are powers of two, pointers wrap on their own
    localparam int OPW = $clog2(`EX_ORDER_DEPTH);
    localparam int OCW = $clog2(`EX_ORDER_DEPTH + 1);
    localparam int APW = $clog2(`EX_ALU_Q_DEPTH);
    localparam int ACW = $clog2(`EX_ALU_Q_DEPTH + 1);
    localparam int RCW = $clog2(`EX_OUT_CREDITS + 1);

    unit_sel_e      ord_q [`EX_ORDER_DEPTH];
    logic [OPW-1:0] ord_wr_q;
    logic [OPW-1:0] ord_rd_q;
    logic [OCW-1:0] ord_cnt_q;
    ex_res_t        alu_q [`EX_ALU_Q_DEPTH];
    logic [APW-1:0] alu_wr_q;
    logic [APW-1:0] alu_rd_q;
    logic [ACW-1:0] alu_cnt_q;
    ex_res_t        md_slot_q;
    logic           md_full_q;
    logic [RCW-1:0] out_cred_q;
    unit_sel_e      head_sel;
    logic           head_ready;
    logic           emit;

    assign head_sel   = ord_q[ord_rd_q];
    assign head_ready = (ord_cnt_q != '0) &&
                        ((head_sel == sel_alu) ? (alu_cnt_q != '0) : md_full_q);
    assign emit       = head_ready && (out_cred_q != '0);

    assign res_valid_o  = emit;
    assign res_o        = (head_sel == sel_alu) ? alu_q[alu_rd_q] : md_slot_q;
    assign alu_credit_o = emit && (head_sel == sel_alu);
    assign md_credit_o  = emit && (head_sel == sel_muldiv);

    always_ff @(posedge clk) begin
        if (ord_push_i) begin
            ord_q[ord_wr_q] <= ord_sel_i;
        end
        if (alu_res_valid_i) begin
            alu_q[alu_wr_q] <= alu_res_i;
        end
        if (md_res_valid_i) begin
            md_slot_q <= md_res_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ord_wr_q   <= '0;
            ord_rd_q   <= '0;
            ord_cnt_q  <= '0;
            alu_wr_q   <= '0;
            alu_rd_q   <= '0;
            alu_cnt_q  <= '0;
            md_full_q  <= 1'b0;
            out_cred_q <= RCW'(`EX_OUT_CREDITS);
        end else begin
            ord_wr_q   <= ord_wr_q + OPW'(ord_push_i);
            ord_rd_q   <= ord_rd_q + OPW'(emit);
            ord_cnt_q  <= ord_cnt_q + OCW'(ord_push_i) - OCW'(emit);
            alu_wr_q   <= alu_wr_q + APW'(alu_res_valid_i);
            alu_rd_q   <= alu_rd_q + APW'(alu_credit_o);
            alu_cnt_q  <= alu_cnt_q + ACW'(alu_res_valid_i) - ACW'(alu_credit_o);
            out_cred_q <= out_cred_q + RCW'(res_credit_i) - RCW'(emit);
            if (md_res_valid_i) begin
                md_full_q <= 1'b1;
            end else if (md_credit_o) begin
                md_full_q <= 1'b0;
            end
        end
    end

endmodule

// File: design/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            op_valid_i,
    input  ex_pkg::ex_op_t  op_i,
    output logic            op_credit_o,
    output logic            res_valid_o,
    output ex_pkg::ex_res_t res_o,
    input  logic            res_credit_i
);
    import ex_pkg::*;

    logic      alu_valid;
    ex_op_t    alu_op;
    logic      md_valid;
    ex_op_t    md_op;
    logic      ord_push;
    unit_sel_e ord_sel;
    logic      alu_credit;
    logic      md_credit;
    logic      alu_res_valid;
    ex_res_t   alu_res;
    logic      md_res_valid;
    ex_res_t   md_res;

    ex_issue i_issue (
        .clk          (clk),
        .reset_i      (reset_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .alu_credit_i (alu_credit),
        .md_credit_i  (md_credit),
        .op_credit_o  (op_credit_o),
        .alu_valid_o  (alu_valid),
        .alu_op_o     (alu_op),
        .md_valid_o   (md_valid),
        .md_op_o      (md_op),
        .ord_push_o   (ord_push),
        .ord_sel_o    (ord_sel)
    );

    ex_alu_unit i_alu_unit (
        .clk         (clk),
        .reset_i     (reset_i),
        .op_valid_i  (alu_valid),
        .op_i        (alu_op),
        .res_valid_o (alu_res_valid),
        .res_o       (alu_res)
    );

    ex_muldiv_unit i_muldiv_unit (
        .clk         (clk),
        .reset_i     (reset_i),
        .op_valid_i  (md_valid),
        .op_i        (md_op),
        .res_valid_o (md_res_valid),
        .res_o       (md_res)
    );

    ex_result_merge i_result_merge (
        .clk             (clk),
        .reset_i         (reset_i),
        .ord_push_i      (ord_push),
        .ord_sel_i       (ord_sel),
        .alu_res_valid_i (alu_res_valid),
        .alu_res_i       (alu_res),
        .md_res_valid_i  (md_res_valid),
        .md_res_i        (md_res),
        .res_credit_i    (res_credit_i),
        .alu_credit_o    (alu_credit),
        .md_credit_o     (md_credit),
        .res_valid_o     (res_valid_o),
        .res_o           (res_o)
    );

endmodule

// File: files.f
+incdir+design
design/ex_pkg.sv
design/ex_issue.sv
design/ex_alu_unit.sv
design/ex_muldiv_unit.sv
design/ex_result_merge.sv
design/ex_stage.sv
tests/ex_stage_tb.sv

// File: tests/ex_stage_tb.sv
`timescale 1ns/100ps
`include "ex_cfg.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam longint SMAX = 2147483647;
    localparam longint SMIN = -SMAX - 1;

    logic            clk;
    logic            reset_i;
    logic            op_valid_i;
    ex_op_t          op_i;
    logic            op_credit_o;
    logic            res_valid_o;
    ex_res_t         res_o;
    logic            res_credit_i;

    logic [31:0]     lfsr_q = 32'hfe51ba68;
    dword_t          m_hilo;                // model copy of hi/lo
    ex_res_t         expected [$];
    int              up_credits;
    int              wb_credits;            // mirrors the merger's output credits
    int              owed;                  // results taken but credit not yet returned
    int              quiet;
    int              hold_cnt;
    logic            allow_hold;
    logic            sent;

    ex_stage i_ex_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .op_credit_o  (op_credit_o),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .res_credit_i (res_credit_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else report_fail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t pick_operand();
        case (2'(lfsr_bits(2)))
            2'd0:    return lfsr_bits(32);
            2'd1:    return 32'(lfsr_bits(4));          // small values including zero
            2'd2: begin
                case (2'(lfsr_bits(2)))
                    2'd0:    return 32'h7fffffff;
                    2'd1:    return 32'h80000000;
                    2'd2:    return 32'hffffffff;
                    default: return 32'h0;
                endcase
            end
            default: return -32'(lfsr_bits(4));         // small negatives
        endcase
    endfunction

    function automatic ex_op_t make_op(input alu_op_e op, input word_t rs, input word_t rt);
        ex_op_t o;
        o.op     = op;
        o.rs_val = rs;
        o.rt_val = rt;
        o.waddr  = 5'(lfsr_bits(5));
        o.we     = 1'b1;
        return o;
    endfunction

    function automatic ex_op_t random_op();
        logic [4:0] code;
        ex_op_t     o;
        code = 5'(lfsr_bits(5));
        if (code > 5'(op_divu)) code = 5'(op_add);
        o    = make_op(alu_op_e'(code), pick_operand(), pick_operand());
        o.we = (2'(lfsr_bits(2)) != 2'd0);
        return o;
    endfunction

    // expected result with the model hi/lo kept in program order
    task automatic model_op(input ex_op_t op, output ex_res_t r);
        word_t  a;
        word_t  b;
        longint sa;
        longint sb;
        longint s64;
        int     n;
        a       = op.rs_val;
        b       = op.rt_val;
        sa      = longint'($signed(a));
        sb      = longint'($signed(b));
        r.waddr = op.waddr;
        r.we    = op.we;
        r.data  = '0;
        r.ovf   = 1'b0;
        case (op.op)
            op_or:   r.data = a | b;
            op_and:  r.data = a & b;
            op_xor:  r.data = a ^ b;
            op_nor:  r.data = ~(a | b);
            op_sll:  r.data = a << b[4:0];
            op_srl:  r.data = a >> b[4:0];
            op_sra: begin
                s64    = sa >>> b[4:0];
                r.data = s64[31:0];
            end
            op_movn, op_movz: begin
                r.data = a;
                r.we   = op.we && ((op.op == op_movn) ? (b != 0) : (b == 0));
            end
            op_add, op_sub: begin
                s64    = (op.op == op_add) ? sa + sb : sa - sb;
                r.data = s64[31:0];
                r.ovf  = (s64 > SMAX) || (s64 < SMIN);
                r.we   = op.we && !r.ovf;
            end
            op_addu: r.data = a + b;
            op_subu: r.data = a - b;
            op_slt:  r.data = (sa < sb) ? 32'd1 : 32'd0;
            op_sltu: r.data = (a < b) ? 32'd1 : 32'd0;
            op_mul: begin
                s64    = sa * sb;
                r.data = s64[31:0];
            end
            op_clz, op_clo: begin
                n = 0;
                while (n < 32 && a[31-n] == (op.op == op_clo)) n++;
                r.data = n;
            end
            op_nop:  r.we = 1'b0;
            default: begin
                // everything else goes through hi/lo
                r.we = 1'b0;
                case (op.op)
                    op_mthi:  m_hilo[63:32] = a;
                    op_mtlo:  m_hilo[31:0] = a;
                    op_mult:  m_hilo = dword_t'(sa * sb);
                    op_multu: m_hilo = {32'h0, a} * {32'h0, b};
                    op_madd:  m_hilo = m_hilo + dword_t'(sa * sb);
                    op_maddu: m_hilo = m_hilo + {32'h0, a} * {32'h0, b};
                    op_msub:  m_hilo = m_hilo - dword_t'(sa * sb);
                    op_msubu: m_hilo = m_hilo - {32'h0, a} * {32'h0, b};
                    op_div: if (b != 0) m_hilo = {32'(sa % sb), 32'(sa / sb)};
                    op_divu: begin
                        if (b != 0) m_hilo = {a % b, a / b};
                    end
                    default: begin
                        r.we   = op.we;
                        r.data = (op.op == op_mfhi) ? m_hilo[63:32] : m_hilo[31:0];
                    end
                endcase
            end
        endcase
    endtask

    // sample outputs at the falling edge and drive the next inputs
    task automatic step_cycle(input logic want, input ex_op_t op, output logic done);
        ex_res_t exp_r;
        ex_res_t new_r;
        @(negedge clk);
        if (op_credit_o) begin
            assert (up_credits < `EX_IN_DEPTH)
                else report_fail("upstream credit returned beyond the buffer depth");
            up_credits++;
        end
        if (res_valid_o) begin
            assert (wb_credits > 0) else report_fail("result sent without a writeback credit");
            assert (expected.size() > 0) else report_fail("result sent with none outstanding");
            exp_r = expected.pop_front();
            check_field("res_o.waddr", 32'(res_o.waddr), 32'(exp_r.waddr));
            check_field("res_o.we", 32'(res_o.we), 32'(exp_r.we));
            check_field("res_o.data", res_o.data, exp_r.data);
            check_field("res_o.ovf", 32'(res_o.ovf), 32'(exp_r.ovf));
            wb_credits--;
            owed++;
            quiet = 0;
        end else if (expected.size() > 0) begin
            quiet++;
            assert (quiet < 400) else report_fail("timeout waiting for a result");
        end
        res_credit_i = 1'b0;
        if (hold_cnt != 0) begin
            hold_cnt--;                                 // writeback stalled
        end else if (allow_hold && lfsr_bits(5) == 0) begin
            hold_cnt = lfsr_bits(6);
        end else if (owed > 0 && lfsr_bits(2) != 0) begin
            res_credit_i = 1'b1;
            owed--;
            wb_credits++;
        end
        done       = 1'b0;
        op_valid_i = 1'b0;
        op_i       = '0;
        if (want && up_credits > 0) begin
            op_valid_i = 1'b1;
            op_i       = op;
            model_op(op, new_r);
            expected.push_back(new_r);
            up_credits--;
            done = 1'b1;
        end
    endtask

    task automatic send_op(input ex_op_t op);
        logic done;
        int   waited;
        done   = 1'b0;
        waited = 0;
        while (!done) begin
            step_cycle(1'b1, op, done);
            waited++;
            assert (waited < 1000) else report_fail("timeout waiting for an upstream credit");
        end
    endtask

    task automatic read_hilo();
        send_op(make_op(op_mfhi, 32'h0, 32'h0));
        send_op(make_op(op_mflo, 32'h0, 32'h0));
    endtask

    task automatic drain_results();
        logic done;
        int   waited;
        waited     = 0;
        allow_hold = 1'b0;
        while (expected.size() > 0 || owed > 0 || hold_cnt > 0) begin
            step_cycle(1'b0, '0, done);
            waited++;
            assert (waited < 5000) else report_fail("timeout while draining results");
        end
        repeat (20) step_cycle(1'b0, '0, done);         // nothing extra may show up
        assert (up_credits == `EX_IN_DEPTH) else report_fail("upstream credits not all returned");
    endtask

    initial begin
        reset_i      = 1'b1;
        op_valid_i   = 1'b0;
        op_i         = '0;
        res_credit_i = 1'b0;
        m_hilo       = '0;
        up_credits   = `EX_IN_DEPTH;
        wb_credits   = `EX_OUT_CREDITS;
        owed         = 0;
        quiet        = 0;
        hold_cnt     = 0;
        allow_hold   = 1'b0;
        repeat (3) @(negedge clk);
        reset_i = 1'b0;
        assert (!op_credit_o && !res_valid_o)
            else report_fail("credit or result valid high after reset");

        send_op(make_op(op_mthi, 32'h12345678, 32'h0));
        send_op(make_op(op_mtlo, 32'h9abcdef0, 32'h0));
        read_hilo();
        send_op(make_op(op_mult, 32'hfffffff9, 32'h00001234));
        read_hilo();
        send_op(make_op(op_multu, 32'hfffffff9, 32'h00001234));
        send_op(make_op(op_madd, 32'h80000000, 32'h7fffffff));
        read_hilo();
        send_op(make_op(op_msubu, 32'hffffffff, 32'hffffffff));
        send_op(make_op(op_maddu, 32'h00010000, 32'h00010000));
        send_op(make_op(op_msub, 32'hffffff00, 32'h00000123));
        read_hilo();
        send_op(make_op(op_div, 32'hffffff9c, 32'h7));  // -100 / 7
        read_hilo();
        send_op(make_op(op_div, 32'd100, 32'hfffffff9));
        read_hilo();
        send_op(make_op(op_div, 32'h80000000, 32'hffffffff));
        send_op(make_op(op_div, 32'h55555555, 32'h0));  // hi/lo must stay
        read_hilo();
        send_op(make_op(op_divu, 32'hfffffff0, 32'h3));
        read_hilo();

        // alu work queued behind a long divide
        allow_hold = 1'b1;
        send_op(make_op(op_divu, 32'hdeadbeef, 32'h00000013));
        send_op(make_op(op_add, 32'h7fffffff, 32'h1));
        send_op(make_op(op_addu, 32'h7fffffff, 32'h1));
        send_op(make_op(op_clz, 32'h00010000, 32'h0));
        send_op(make_op(op_clo, 32'hfff00000, 32'h0));
        send_op(make_op(op_movz, 32'h1234, 32'h0));
        send_op(make_op(op_movn, 32'h1234, 32'h0));
        read_hilo();

        for (int i = 0; i < 600; i++) begin
            if (lfsr_bits(3) == 0) step_cycle(1'b0, '0, sent);
            send_op(random_op());
        end
        drain_results();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
